/* run.sh */
#!/bin/sh
# build and run the sd host testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_sd_host -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

/* source/sd_host.sv */
`timescale 1ns/1ns

module sd_host #(
  parameter int SLOW_DIV = 125,
  parameter int FAST_DIV = 2
) (
  input logic clk,
  input logic rst_n,
  input logic [31:0] block_addr,
  output logic sd_sclk,
  output logic sd_cs_n,
  output logic sd_mosi,
  input logic sd_miso,
  output logic [7:0] data_byte,
  output logic data_valid,
  input logic data_ready,
  output logic init_done,
  output logic init_error,
  output logic card_hc
);

  // engine to clock divider
  logic spi_run;
  logic spi_pause;
  logic spi_fast;
  logic spi_rise;
  logic spi_fall;
  // sequencer to engine
  logic init_clocks;
  logic fast_en;

  sd_xfer_if xfer_bus (.clk(clk));

  sd_spi_clock #(
    .SLOW_DIV(SLOW_DIV),
    .FAST_DIV(FAST_DIV)
  ) clock_inst (
    .clk(clk),
    .rst_n(rst_n),
    .run(spi_run),
    .pause(spi_pause),
    .fast(spi_fast),
    .sclk(sd_sclk),
    .rise(spi_rise),
    .fall(spi_fall)
  );

  sd_spi_transfer transfer_inst (
    .clk(clk),
    .rst_n(rst_n),
    .xfer(xfer_bus.engine),
    .init_clocks(init_clocks),
    .fast_en(fast_en),
    .run(spi_run),
    .pause(spi_pause),
    .fast(spi_fast),
    .rise(spi_rise),
    .fall(spi_fall),
    .mosi(sd_mosi),
    .miso(sd_miso),
    .data_byte(data_byte),
    .data_valid(data_valid),
    .data_ready(data_ready)
  );

  sd_init_fsm init_inst (
    .clk(clk),
    .rst_n(rst_n),
    .xfer(xfer_bus.init),
    .block_addr(block_addr),
    .init_clocks(init_clocks),
    .fast_en(fast_en),
    .cs_n(sd_cs_n),
    .init_done(init_done),
    .init_error(init_error),
    .card_hc(card_hc)
  );

endmodule

/* source/sd_init_fsm.sv */
`timescale 1ns/1ns

module sd_init_fsm (
  input logic clk,
  input logic rst_n,
  sd_xfer_if.init xfer,
  input sd_pkg::cmd_arg_t block_addr,
  output logic init_clocks,
  output logic fast_en,
  output logic cs_n,
  output logic init_done,
  output logic init_error,
  output logic card_hc
);

  // acmd41 with hcs, host handles high capacity
  localparam sd_pkg::cmd_arg_t HCS_ARG = 32'h4000_0000;

  sd_pkg::init_state_t state;
  logic [3:0] retry;
  sd_pkg::byte_t r1;
  logic last_try;
  logic active;
  logic if_cond_ok;

  assign r1 = xfer.resp[39:32];
  assign last_try = (retry == 4'(sd_pkg::RETRY_LIMIT - 1));
  assign active = !(state inside {sd_pkg::ST_DONE, sd_pkg::ST_ERROR});

  // legacy card rejects cmd8, v2 card echoes the pattern
  assign if_cond_ok = (r1 == sd_pkg::R1_ILLEGAL_IDLE) ||
                      (r1 == sd_pkg::R1_IDLE &&
                       xfer.resp[11:0] == sd_pkg::IF_COND_ARG[11:0]);

  assign init_clocks = (state == sd_pkg::ST_POWER);
  // card deselected for idle clocks and once finished
  assign cs_n = (state inside {sd_pkg::ST_POWER, sd_pkg::ST_DONE, sd_pkg::ST_ERROR});
  assign init_done = (state == sd_pkg::ST_DONE);
  assign init_error = (state == sd_pkg::ST_ERROR);

  // command fields follow the state
  always_comb begin
    xfer.index = sd_pkg::CMD_GO_IDLE;
    xfer.arg = '0;
    xfer.long_resp = 1'b0;
    xfer.with_data = 1'b0;
    case (state)
      sd_pkg::ST_CMD8: begin
        xfer.index = sd_pkg::CMD_SEND_IF_COND;
        xfer.arg = sd_pkg::IF_COND_ARG;
        xfer.long_resp = 1'b1;
      end
      sd_pkg::ST_CMD58A, sd_pkg::ST_CMD58B: begin
        xfer.index = sd_pkg::CMD_READ_OCR;
        xfer.long_resp = 1'b1;
      end
      sd_pkg::ST_CMD55: begin
        xfer.index = sd_pkg::CMD_APP;
      end
      sd_pkg::ST_ACMD41: begin
        xfer.index = sd_pkg::ACMD_OP_COND;
        xfer.arg = HCS_ARG;
      end
      sd_pkg::ST_CMD16: begin
        xfer.index = sd_pkg::CMD_SET_BLOCKLEN;
        xfer.arg = sd_pkg::cmd_arg_t'(sd_pkg::BLOCK_BYTES);
      end
      sd_pkg::ST_CMD17: begin
        // sdhc takes block numbers, sdsc takes byte addresses
        xfer.index = sd_pkg::CMD_READ_SINGLE;
        xfer.arg = card_hc ? block_addr : {block_addr[22:0], 9'd0};
        xfer.with_data = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sd_pkg::ST_POWER;
      xfer.req <= 1'b0;
      retry <= '0;
      fast_en <= 1'b0;
      card_hc <= 1'b0;
    end else if (xfer.done) begin
      xfer.req <= 1'b0;
      case (state)
        sd_pkg::ST_POWER: begin
          state <= sd_pkg::ST_CMD0;
        end
        sd_pkg::ST_CMD0: begin
          // retried until idle, timeouts included
          if (!xfer.timeout && r1 == sd_pkg::R1_IDLE) begin
            retry <= '0;
            state <= sd_pkg::ST_CMD8;
          end else if (last_try) begin
            state <= sd_pkg::ST_ERROR;
          end else begin
            retry <= retry + 1'b1;
          end
        end
        sd_pkg::ST_CMD8: begin
          state <= (!xfer.timeout && if_cond_ok) ? sd_pkg::ST_CMD58A : sd_pkg::ST_ERROR;
        end
        sd_pkg::ST_CMD58A: begin
          if (xfer.timeout) begin
            state <= sd_pkg::ST_ERROR;
          end else begin
            // ccs is ocr bit 30
            card_hc <= xfer.resp[30];
            state <= sd_pkg::ST_CMD55;
          end
        end
        sd_pkg::ST_CMD55: begin
          state <= xfer.timeout ? sd_pkg::ST_ERROR : sd_pkg::ST_ACMD41;
        end
        sd_pkg::ST_ACMD41: begin
          if (xfer.timeout) begin
            state <= sd_pkg::ST_ERROR;
          end else if (r1 == 8'h00) begin
            state <= sd_pkg::ST_CMD58B;
          end else if (r1 == sd_pkg::R1_IDLE) begin
            // still powering up, another cmd55/acmd41 pair
            if (last_try) begin
              state <= sd_pkg::ST_ERROR;
            end else begin
              retry <= retry + 1'b1;
              state <= sd_pkg::ST_CMD55;
            end
          end else begin
            state <= sd_pkg::ST_ERROR;
          end
        end
        sd_pkg::ST_CMD58B: begin
          if (xfer.timeout) begin
            state <= sd_pkg::ST_ERROR;
          end else begin
            // card ready, fast clock from the next transfer
            fast_en <= 1'b1;
            state <= sd_pkg::ST_CMD16;
          end
        end
        sd_pkg::ST_CMD16: begin
          state <= (xfer.timeout || r1 != 8'h00) ? sd_pkg::ST_ERROR : sd_pkg::ST_CMD17;
        end
        sd_pkg::ST_CMD17: begin
          state <= (xfer.timeout || r1 != 8'h00) ? sd_pkg::ST_ERROR : sd_pkg::ST_DONE;
        end
        default: begin
        end
      endcase
    end else if (active && !xfer.req && !xfer.busy) begin
      xfer.req <= 1'b1;
    end
  end

  a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
    !(init_done && init_error));

  // outcome holds until reset
  a_outcome_final: assert property (@(posedge clk) disable iff (!rst_n)
    init_done || init_error |=> $stable({init_done, init_error}));

endmodule

/* source/sd_pkg.sv */
package sd_pkg;

  // bus widths
  typedef logic [7:0] byte_t;
  typedef logic [5:0] cmd_index_t;
  typedef logic [31:0] cmd_arg_t;
  typedef logic [6:0] crc7_t;
  // 01, index, argument, crc7, end bit
  typedef logic [47:0] frame_t;
  // r1 in the top byte, r3/r7 payload below it
  typedef logic [39:0] resp_t;

  // command indices used by the init sequence
  localparam cmd_index_t CMD_GO_IDLE = 6'd0;
  localparam cmd_index_t CMD_SEND_IF_COND = 6'd8;
  localparam cmd_index_t CMD_APP = 6'd55;
  localparam cmd_index_t ACMD_OP_COND = 6'd41;
  localparam cmd_index_t CMD_READ_OCR = 6'd58;
  localparam cmd_index_t CMD_SET_BLOCKLEN = 6'd16;
  localparam cmd_index_t CMD_READ_SINGLE = 6'd17;

  // 2.7-3.6 V range plus 0xaa check pattern
  localparam cmd_arg_t IF_COND_ARG = 32'h0000_01AA;

  // r1 values and the block start token
  localparam byte_t R1_IDLE = 8'h01;
  localparam byte_t R1_ILLEGAL_IDLE = 8'h05;
  localparam byte_t DATA_TOKEN = 8'hFE;

  localparam int BLOCK_BYTES = 512;
  // limits, counted in spi bytes
  localparam int RESP_TIMEOUT_BYTES = 16;
  localparam int TOKEN_TIMEOUT_BYTES = 128;
  localparam int RETRY_LIMIT = 10;
  // idle clocks with cs_n high before cmd0
  localparam int INIT_CLOCKS = 80;

  // init sequencer states, in command order
  typedef enum logic [3:0] {
    ST_POWER,
    ST_CMD0,
    ST_CMD8,
    ST_CMD58A,
    ST_CMD55,
    ST_ACMD41,
    ST_CMD58B,
    ST_CMD16,
    ST_CMD17,
    ST_DONE,
    ST_ERROR
  } init_state_t;

endpackage

/* source/sd_spi_clock.sv */
`timescale 1ns/1ns

module sd_spi_clock #(
  parameter int SLOW_DIV = 125,
  parameter int FAST_DIV = 2
) (
  input logic clk,
  input logic rst_n,
  input logic run,
  input logic pause,
  input logic fast,
  output logic sclk,
  output logic rise,
  output logic fall
);

  // counter wide enough for the slower half-period
  localparam int CW = $clog2(SLOW_DIV > FAST_DIV ? SLOW_DIV : FAST_DIV) + 1;

  logic [CW-1:0] cnt;
  logic [CW-1:0] limit;
  logic hold;
  logic tick;

  // last count of the current half-period
  assign limit = fast ? CW'(FAST_DIV - 1) : CW'(SLOW_DIV - 1);

  // pause only bites once sclk is low
  assign hold = pause && !sclk;
  assign tick = run && !hold && (cnt >= limit);

  // strobes in the cycle that toggles sclk
  assign rise = tick && !sclk;
  assign fall = tick && sclk;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
      sclk <= 1'b0;
    end else if (!run) begin
      // parked low between transfers
      cnt <= '0;
      sclk <= 1'b0;
    end else if (!hold) begin
      if (tick) begin
        cnt <= '0;
        sclk <= ~sclk;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  a_one_edge: assert property (@(posedge clk) disable iff (!rst_n) !(rise && fall));

endmodule

/* source/sd_spi_transfer.sv */
`timescale 1ns/1ns

module sd_spi_transfer (
  input logic clk,
  input logic rst_n,
  sd_xfer_if.engine xfer,
  input logic init_clocks,
  input logic fast_en,
  output logic run,
  output logic pause,
  output logic fast,
  input logic rise,
  input logic fall,
  output logic mosi,
  input logic miso,
  output sd_pkg::byte_t data_byte,
  output logic data_valid,
  input logic data_ready
);

  typedef enum logic [3:0] {
    X_IDLE,
    X_CLOCKS,
    X_CMD,
    X_RESP,
    X_TOKEN,
    X_DATA,
    X_CRC,
    X_TAIL,
    X_FIN
  } xfer_state_t;

  // limits in spi bits
  localparam int RESP_LIMIT = sd_pkg::RESP_TIMEOUT_BYTES * 8;
  localparam int TOKEN_LIMIT = sd_pkg::TOKEN_TIMEOUT_BYTES * 8;
  localparam int BLOCK_BITS = sd_pkg::BLOCK_BYTES * 8;

  xfer_state_t state;
  // bit counter, reused by every phase
  logic [12:0] cnt;
  logic started;
  sd_pkg::frame_t frame;
  sd_pkg::crc7_t crc;
  sd_pkg::resp_t rbuf;
  sd_pkg::resp_t rnext;
  sd_pkg::byte_t r1_now;
  logic [5:0] resp_len;
  logic cmd_bit;

  // serial crc7, poly x^7 + x^3 + 1
  function automatic sd_pkg::crc7_t crc7_step(input sd_pkg::crc7_t c, input logic b);
    logic fb;
    fb = c[6] ^ b;
    return {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
  endfunction

  // shift register view after the bit on this rise
  assign rnext = {rbuf[38:0], miso};
  assign r1_now = xfer.long_resp ? rnext[39:32] : rnext[7:0];
  assign resp_len = xfer.long_resp ? 6'd40 : 6'd8;

  assign xfer.busy = (state != X_IDLE);
  assign xfer.done = (state == X_FIN);
  assign run = !(state inside {X_IDLE, X_FIN});

  // stop sclk low while a byte waits on the stream
  assign pause = data_valid && !data_ready;

  // 8 preamble ones, 40 frame bits, crc7, end bit
  always_comb begin
    if (cnt < 13'd8) begin
      cmd_bit = 1'b1;
    end else if (cnt >= 13'd48 && cnt < 13'd55) begin
      cmd_bit = crc[6];
    end else begin
      cmd_bit = frame[47];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= X_IDLE;
      cnt <= '0;
      started <= 1'b0;
      mosi <= 1'b1;
      fast <= 1'b0;
      data_valid <= 1'b0;
      xfer.timeout <= 1'b0;
    end else begin
      if (data_valid && data_ready) begin
        data_valid <= 1'b0;
      end
      case (state)
        X_IDLE: begin
          if (xfer.req) begin
            // rate picked once per transfer
            fast <= fast_en;
            cnt <= '0;
            started <= 1'b0;
            xfer.timeout <= 1'b0;
            frame <= {2'b01, xfer.index, xfer.arg, 7'd0, 1'b1};
            crc <= '0;
            state <= init_clocks ? X_CLOCKS : X_CMD;
          end
        end
        X_CLOCKS: begin
          if (fall) begin
            cnt <= cnt + 1'b1;
            if (cnt == 13'(sd_pkg::INIT_CLOCKS - 1)) begin
              state <= X_FIN;
            end
          end
        end
        X_CMD: begin
          // mosi moves on the falling edge
          if (fall) begin
            mosi <= cmd_bit;
            cnt <= cnt + 1'b1;
            if (cnt >= 13'd8) begin
              frame <= frame << 1;
            end
            if (cnt >= 13'd8 && cnt < 13'd48) begin
              crc <= crc7_step(crc, frame[47]);
            end else if (cnt >= 13'd48 && cnt < 13'd55) begin
              crc <= crc << 1;
            end
            // end bit is a one so mosi idles high after it
            if (cnt == 13'd55) begin
              cnt <= '0;
              state <= X_RESP;
            end
          end
        end
        X_RESP: begin
          if (rise) begin
            if (!started) begin
              // hunt for the r1 start bit
              if (!miso) begin
                started <= 1'b1;
                rbuf <= rnext;
                cnt <= 13'd1;
              end else if (cnt == 13'(RESP_LIMIT - 1)) begin
                xfer.timeout <= 1'b1;
                state <= X_TAIL;
              end else begin
                cnt <= cnt + 1'b1;
              end
            end else begin
              rbuf <= rnext;
              cnt <= cnt + 1'b1;
              if (cnt == {7'd0, resp_len - 6'd1}) begin
                xfer.resp <= xfer.long_resp ? rnext : {r1_now, 32'd0};
                cnt <= '0;
                // all ones so the token window starts clean
                rbuf <= '1;
                state <= (xfer.with_data && r1_now == 8'h00) ? X_TOKEN : X_TAIL;
              end
            end
          end
        end
        X_TOKEN: begin
          // sliding window, token matches at any bit offset
          if (rise) begin
            rbuf <= rnext;
            cnt <= cnt + 1'b1;
            if (rnext[7:0] == sd_pkg::DATA_TOKEN) begin
              cnt <= '0;
              state <= X_DATA;
            end else if (cnt == 13'(TOKEN_LIMIT - 1)) begin
              xfer.timeout <= 1'b1;
              state <= X_TAIL;
            end
          end
        end
        X_DATA: begin
          if (rise) begin
            rbuf <= rnext;
            cnt <= cnt + 1'b1;
            if (cnt[2:0] == 3'd7) begin
              data_byte <= rnext[7:0];
              data_valid <= 1'b1;
            end
            if (cnt == 13'(BLOCK_BITS - 1)) begin
              cnt <= '0;
              state <= X_CRC;
            end
          end
        end
        X_CRC: begin
          // crc16 clocked in and dropped
          if (rise) begin
            cnt <= cnt + 1'b1;
            if (cnt == 13'd15) begin
              state <= X_TAIL;
            end
          end
        end
        X_TAIL: begin
          // finish the high phase before parking sclk
          if (fall) begin
            state <= X_FIN;
          end
        end
        default: begin
          state <= X_IDLE;
        end
      endcase
    end
  end

  a_byte_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_valid && !data_ready |=> $stable(data_byte));

endmodule

/* source/sd_xfer_if.sv */
`timescale 1ns/1ns

interface sd_xfer_if (
  input logic clk
);

  // request side, held stable until done
  logic req;
  sd_pkg::cmd_index_t index;
  sd_pkg::cmd_arg_t arg;
  logic long_resp;
  logic with_data;

  // engine side, resp and timeout valid with done
  logic busy;
  logic done;
  sd_pkg::resp_t resp;
  logic timeout;

  modport init (
    input busy, done, resp, timeout,
    output req, index, arg, long_resp, with_data
  );

  modport engine (
    input req, index, arg, long_resp, with_data,
    output busy, done, resp, timeout
  );

  // done only answers a pending request
  a_done_with_req: assert property (@(posedge clk) done |-> req);

  // request and its command held until answered
  a_req_held: assert property (@(posedge clk)
    req && !done |=> req && $stable(index) && $stable(arg));

endinterface

/* tb.f */
source/sd_pkg.sv
source/sd_xfer_if.sv
source/sd_spi_clock.sv
source/sd_spi_transfer.sv
source/sd_init_fsm.sv
source/sd_host.sv
verification/tb_sd_host.sv

/* verification/tb_sd_host.sv */
`timescale 1ns/1ns

module tb_sd_host;

  // spi half-periods in clk cycles
  localparam int SLOW_DIV = 4;
  localparam int FAST_DIV = 1;
  localparam int CLK_NS = 4;
  localparam int NUM_TESTS = 6;
  // protocol values the card model works from
  localparam int INIT_CLOCKS = 80;
  localparam int RETRY_LIMIT = 10;
  localparam int BLOCK_BYTES = 512;
  // worst-case init taken as 4000 slow spi bit periods per test
  localparam int WATCHDOG_NS = NUM_TESTS * 4000 * 2 * SLOW_DIV * CLK_NS;

  logic clk;
  logic rst_n;
  logic [31:0] block_addr;
  logic sd_sclk;
  logic sd_cs_n;
  logic sd_mosi;
  logic sd_miso;
  logic [7:0] data_byte;
  logic data_valid;
  logic data_ready;
  logic init_done;
  logic init_error;
  logic card_hc;

  // lfsr for test choices and card answers
  logic [15:0] rnd_state = 16'd1149;
  // lfsr for data_ready
  logic [15:0] ready_state = 16'd1149;

  // per-test card choices
  logic legacy;
  logic ccs;
  logic token_ok;
  int idle_target;
  logic [7:0] block [0:BLOCK_BYTES-1];

  // card model state
  logic [47:0] rx_sr;
  int rx_cnt;
  logic tx_q[$];
  int exp_cmd;
  int cmd58_count;
  int idle_given;
  int rise_count;
  int bytes_taken;
  logic switch_pending;
  logic fast_armed;

  // sclk phase monitor
  logic prev_sclk;
  int phase_len;
  logic fast_exp;

  int errors;
  int n_pass;
  int n_fail;

  sd_host #(
    .SLOW_DIV(SLOW_DIV),
    .FAST_DIV(FAST_DIV)
  ) sd_host_inst (
    .clk(clk),
    .rst_n(rst_n),
    .block_addr(block_addr),
    .sd_sclk(sd_sclk),
    .sd_cs_n(sd_cs_n),
    .sd_mosi(sd_mosi),
    .sd_miso(sd_miso),
    .data_byte(data_byte),
    .data_valid(data_valid),
    .data_ready(data_ready),
    .init_done(init_done),
    .init_error(init_error),
    .card_hc(card_hc)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      rnd_state = lfsr_step(rnd_state);
      v = {v[30:0], rnd_state[0]};
    end
    return v;
  endfunction

  // remainder of msg * x^7 divided by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_ref(input logic [39:0] msg);
    logic [46:0] r;
    int i;
    r = {msg, 7'd0};
    for (i = 46; i >= 7; i--) begin
      if (r[i]) begin
        r[i -: 8] = r[i -: 8] ^ 8'h89;
      end
    end
    return r[6:0];
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic push_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--) begin
      tx_q.push_back(b[i]);
    end
  endtask

  task automatic push_word(input logic [31:0] w);
    push_byte(w[31:24]);
    push_byte(w[23:16]);
    push_byte(w[15:8]);
    push_byte(w[7:0]);
  endtask

  // check one received frame and queue the card's answer
  task automatic decode_frame(input logic [47:0] f);
    int idx;
    logic [31:0] arg;
    logic [6:0] crc_exp;
    logic [31:0] exp_arg;
    int delay;
    int i;
    idx = int'(f[45:40]);
    arg = f[39:8];
    crc_exp = crc7_ref(f[47:8]);
    if (f[47:46] != 2'b01 || f[0] != 1'b1) begin
      note_error($sformatf("frame for command %0d has bad start or end bits", idx));
    end
    if (f[7:1] != crc_exp) begin
      note_error($sformatf("Mismatch crc7 of cmd%0d: expected %h, got %h", idx, crc_exp, f[7:1]));
    end
    if (idx != exp_cmd) begin
      note_error($sformatf("command %0d out of order, expected %0d", idx, exp_cmd));
    end else begin
      // 1 to 4 bytes of 0xff before the answer
      delay = 1 + int'(rand_bits(2));
      for (i = 0; i < delay; i++) begin
        push_byte(8'hFF);
      end
      case (idx)
        0: begin
          push_byte(8'h01);
          exp_cmd = 8;
        end
        8: begin
          if (arg != 32'h0000_01AA) begin
            note_error($sformatf("Mismatch cmd8 arg: expected %h, got %h", 32'h1AA, arg));
          end
          if (legacy) begin
            // old card answers illegal command plus idle
            push_byte(8'h05);
          end else begin
            push_byte(8'h01);
            push_word({20'd0, arg[11:0]});
          end
          exp_cmd = 58;
        end
        58: begin
          cmd58_count++;
          push_byte(cmd58_count == 1 ? 8'h01 : 8'h00);
          // power-up done bit, ccs and the 2.7-3.6 V window
          push_word({1'b1, ccs, 6'd0, 24'hFF8000});
          if (cmd58_count == 1) begin
            exp_cmd = 55;
          end else begin
            exp_cmd = 16;
            switch_pending = 1'b1;
          end
        end
        55: begin
          push_byte(8'h01);
          exp_cmd = 41;
        end
        41: begin
          if (idle_given < idle_target) begin
            push_byte(8'h01);
            idle_given++;
            exp_cmd = (idle_given == RETRY_LIMIT) ? -1 : 55;
          end else begin
            push_byte(8'h00);
            exp_cmd = 58;
          end
        end
        16: begin
          if (arg != 32'd512) begin
            note_error($sformatf("Mismatch cmd16 arg: expected %h, got %h", 32'd512, arg));
          end
          push_byte(8'h00);
          exp_cmd = 17;
        end
        17: begin
          // sdsc takes a byte address
          exp_arg = ccs ? block_addr : (block_addr << 9);
          if (arg != exp_arg) begin
            note_error($sformatf("Mismatch cmd17 arg: expected %h, got %h", exp_arg, arg));
          end
          push_byte(8'h00);
          if (token_ok) begin
            delay = 1 + int'(rand_bits(2));
            for (i = 0; i < delay; i++) begin
              push_byte(8'hFF);
            end
            push_byte(8'hFE);
            for (i = 0; i < BLOCK_BYTES; i++) begin
              push_byte(block[i]);
            end
            // crc16 that the host ignores
            push_byte(8'(rand_bits(8)));
            push_byte(8'(rand_bits(8)));
          end
          exp_cmd = -1;
        end
        default: begin
        end
      endcase
    end
  endtask

  // mosi in on rising sclk
  always @(posedge sd_sclk) begin
    if (rst_n) begin
      rise_count++;
      if (rise_count <= INIT_CLOCKS && !sd_cs_n) begin
        note_error("cs_n went low during the power-up clocks");
      end
      if (rise_count == INIT_CLOCKS + 1 && sd_cs_n) begin
        note_error("more than 80 power-up clocks with cs_n high");
      end
      if (!sd_cs_n) begin
        if (rx_cnt == 0) begin
          // start bit
          if (!sd_mosi) begin
            rx_sr = '0;
            rx_cnt = 1;
          end
        end else begin
          rx_sr = {rx_sr[46:0], sd_mosi};
          rx_cnt++;
          if (rx_cnt == 48) begin
            decode_frame(rx_sr);
            rx_cnt = 0;
          end
        end
      end
    end
  end

  // miso out on falling sclk
  always @(negedge sd_sclk) begin
    if (rst_n && !sd_cs_n) begin
      // empty queue after the 2nd cmd58 means this fall ends that transfer
      if (switch_pending && tx_q.size() == 0) begin
        switch_pending = 1'b0;
        fast_armed = 1'b1;
      end
      #1;
      if (tx_q.size() > 0) begin
        sd_miso = tx_q.pop_front();
      end else begin
        sd_miso = 1'b1;
      end
    end
  end

  // sclk half-periods in clk cycles
  always @(negedge clk) begin
    int exp_half;
    if (!rst_n) begin
      prev_sclk = 1'b0;
      phase_len = 0;
      fast_exp = 1'b0;
    end else if (sd_sclk != prev_sclk) begin
      if (prev_sclk) begin
        exp_half = fast_exp ? FAST_DIV : SLOW_DIV;
        if (phase_len != exp_half) begin
          note_error($sformatf("Mismatch sclk high phase: expected %h, got %h",
                               exp_half, phase_len));
        end
      end else begin
        if (fast_armed) begin
          fast_exp = 1'b1;
          fast_armed = 1'b0;
        end
        if (!fast_exp && phase_len < SLOW_DIV) begin
          note_error($sformatf("sclk low phase of %0d cycles at the slow rate", phase_len));
        end
      end
      prev_sclk = sd_sclk;
      phase_len = 1;
    end else begin
      phase_len++;
    end
  end

  // a block byte moves when valid and ready
  always @(negedge clk) begin
    if (rst_n && data_valid && data_ready) begin
      if (init_error) begin
        note_error("block byte accepted after init_error");
      end else if (bytes_taken >= BLOCK_BYTES) begin
        note_error("more than 512 block bytes accepted");
      end else if (data_byte != block[bytes_taken]) begin
        note_error($sformatf("Mismatch data_byte[%0d]: expected %h, got %h",
                             bytes_taken, block[bytes_taken], data_byte));
      end
      bytes_taken++;
    end
  end

  always @(posedge clk) begin
    #1;
    ready_state = lfsr_step(ready_state);
    data_ready = ready_state[0];
  end

  task automatic clear_model();
    rx_sr = '0;
    rx_cnt = 0;
    tx_q.delete();
    exp_cmd = 0;
    cmd58_count = 0;
    idle_given = 0;
    rise_count = 0;
    bytes_taken = 0;
    switch_pending = 1'b0;
    fast_armed = 1'b0;
    sd_miso = 1'b1;
  endtask

  task automatic run_test(input int t);
    int err_start;
    int i;
    logic expect_ok;
    logic [31:0] addr;
    err_start = errors;
    legacy = (rand_bits(1) != 0);
    ccs = (rand_bits(1) != 0);
    idle_target = int'(rand_bits(4));
    token_ok = (rand_bits(2) != 0);
    // last two tests take the error paths
    if (t == NUM_TESTS - 2) begin
      token_ok = 1'b0;
    end
    if (t == NUM_TESTS - 1) begin
      idle_target = RETRY_LIMIT + 2;
    end
    addr = rand_bits(32);
    for (i = 0; i < BLOCK_BYTES; i++) begin
      block[i] = 8'(rand_bits(8));
    end
    expect_ok = (idle_target < RETRY_LIMIT) && token_ok;

    @(posedge clk);
    #1;
    rst_n = 1'b0;
    block_addr = addr;
    clear_model();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    while (!(init_done || init_error)) begin
      @(negedge clk);
    end
    // let any stray byte or frame show up
    repeat (40) @(negedge clk);

    if (init_done != expect_ok) begin
      note_error($sformatf("Mismatch init_done: expected %h, got %h", expect_ok, init_done));
    end
    if (init_error != !expect_ok) begin
      note_error($sformatf("Mismatch init_error: expected %h, got %h", !expect_ok, init_error));
    end
    if (!sd_cs_n) begin
      note_error("cs_n is low after the end of init");
    end
    if (card_hc != ccs) begin
      note_error($sformatf("Mismatch card_hc: expected %h, got %h", ccs, card_hc));
    end
    if (bytes_taken != (expect_ok ? BLOCK_BYTES : 0)) begin
      note_error($sformatf("Mismatch block byte count: expected %h, got %h",
                           expect_ok ? BLOCK_BYTES : 0, bytes_taken));
    end
    if (exp_cmd != -1) begin
      note_error($sformatf("command sequence stopped early, next command was %0d", exp_cmd));
    end
    if (idle_target < RETRY_LIMIT && !fast_exp) begin
      note_error("sclk never switched to the fast rate");
    end

    if (errors == err_start) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d: %s legacy=%0d ccs=%0d idle_acmd41=%0d token=%0d bytes=%0d",
             t, (errors == err_start) ? "ok" : "FAIL", legacy, ccs, idle_target,
             token_ok, bytes_taken);
  endtask

  initial begin
    int t;
    clk = 1'b0;
    rst_n = 1'b0;
    block_addr = '0;
    sd_miso = 1'b1;
    data_ready = 1'b0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    clear_model();
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("run stopped, init did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

endmodule
